/* verilog/sys_cont_pkg.sv */
package sys_cont_pkg;

  localparam int num_ints = 16;

  typedef logic [3:0]          vec_idx_t;
  typedef logic [num_ints-1:0] int_vec_t;
  typedef logic [31:0]         addr_t;
  typedef logic [31:0]         word_t;
  typedef logic [15:0]         seg_t;

  // one bit per pipeline stage, front to back
  typedef struct packed {
    logic fetch;
    logic decode_0;
    logic decode_1;
    logic register;
    logic address;
    logic execute;
    logic writeback;
  } flush_t;

  typedef struct packed {
    flush_t flush;
    logic   fetch_load;
    addr_t  fetch_addr;
    logic   load_cs;
    seg_t   cs;
    logic   load_eip;
    word_t  eip;
    logic   load_eflags;
    word_t  eflags;
  } redirect_t;

  ////////////////////////////////////////////////////////////
  // wishbone classic, read only
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic  cyc;
    logic  stb;
    addr_t adr;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_rsp_t;

  // a stack word is either a whole value or a selector in the low half
  typedef union packed {
    word_t word;
    struct packed {
      logic [15:0] upper;
      seg_t        cs;
    } half;
  } pop_word_u;

  typedef struct packed {
    logic      valid;
    pop_word_u data;
  } pop_t;

  typedef struct packed {
    logic  load;
    addr_t address;
    logic  load_cs;
    seg_t  cs;
  } jump_t;

  // everything ahead of writeback
  localparam flush_t flush_front = '{
    fetch:     1'b1,
    decode_0:  1'b1,
    decode_1:  1'b1,
    register:  1'b1,
    address:   1'b1,
    execute:   1'b1,
    writeback: 1'b0
  };

  typedef enum logic [1:0] {
    idle,
    pop_eflags,
    pop_cs,
    pop_eip
  } ret_state_t;

endpackage

/* verilog/int_latch.sv */
`timescale 1ns/100ps

module int_latch (
  input  logic                   clk,
  input  logic                   arst_n,
  input  sys_cont_pkg::int_vec_t int_vec,
  input  logic                   clear,
  input  sys_cont_pkg::vec_idx_t clear_idx,
  output logic                   pending,
  output sys_cont_pkg::vec_idx_t serv_idx
);

  import sys_cont_pkg::*;

  int_vec_t latched;
  int_vec_t clear_mask;

  ////////////////////////////////////////////////////////////
  // sticky vector
  ////////////////////////////////////////////////////////////

  // only the serviced line is dropped
  always_comb begin
    clear_mask = '0;
    if (clear) begin
      clear_mask[clear_idx] = 1'b1;
    end
  end

  // new lines are ORed in after the clear, so a fresh
  // raise on the cleared line is kept
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      latched <= '0;
    end else begin
      latched <= (latched & ~clear_mask) | int_vec;
    end
  end

  ////////////////////////////////////////////////////////////
  // priority
  ////////////////////////////////////////////////////////////

  assign pending = |latched;

  // scan from the top so the lowest set index is left standing
  always_comb begin
    serv_idx = '0;
    for (int i = num_ints - 1; i >= 0; i--) begin
      if (latched[i]) begin
        serv_idx = vec_idx_t'(i);
      end
    end
  end

  // the sequencer must only retire a line it actually took
  clear_names_set_bit : assert property (
    @(posedge clk) disable iff (!arst_n)
    clear |-> latched[clear_idx]
  ) else $error("int_latch: clear of line %0d which is not pending", clear_idx);

endmodule

/* verilog/int_sequencer.sv */
`timescale 1ns/100ps

module int_sequencer #(
  parameter sys_cont_pkg::addr_t idt_base = 32'h4000
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    pending,
  input  sys_cont_pkg::vec_idx_t  serv_idx,
  input  logic                    hold_int,
  input  logic                    decode_end_int,
  input  sys_cont_pkg::wb_rsp_t   wb_rsp,
  output logic                    decode_start_int,
  output sys_cont_pkg::wb_req_t   wb_req,
  output logic                    clear,
  output sys_cont_pkg::vec_idx_t  clear_idx,
  output sys_cont_pkg::redirect_t req
);

  import sys_cont_pkg::*;

  typedef enum logic [1:0] {
    int_idle,
    int_drain,
    int_read,
    int_redirect
  } seq_state_t;

  seq_state_t state;
  seq_state_t state_nx;
  vec_idx_t   cur_idx;
  addr_t      handler;

  ////////////////////////////////////////////////////////////
  // service fsm
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_nx = state;
    case (state)
      int_idle:     if (pending && !hold_int) state_nx = int_drain;
      int_drain:    if (decode_end_int) state_nx = int_read;
      int_read:     if (wb_rsp.ack) state_nx = int_redirect;
      int_redirect: state_nx = int_idle;
      default:      state_nx = int_idle;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= int_idle;
    end else begin
      state <= state_nx;
    end
  end

  // index is frozen on leaving idle so later lines wait for the next round
  always_ff @(posedge clk) begin
    if (state == int_idle) begin
      cur_idx <= serv_idx;
    end
    if (state == int_read && wb_rsp.ack) begin
      handler <= wb_rsp.dat;
    end
  end

  assign decode_start_int = (state == int_drain);

  // idt entry is four bytes per vector
  assign wb_req.cyc = (state == int_read);
  assign wb_req.stb = (state == int_read);
  assign wb_req.adr = idt_base + {26'd0, cur_idx, 2'b00};

  assign clear     = (state == int_redirect);
  assign clear_idx = cur_idx;

  always_comb begin
    req = '0;
    if (state == int_redirect) begin
      req.flush      = flush_front;
      req.fetch_load = 1'b1;
      req.fetch_addr = handler;
    end
  end

  // request held steady through wait states and dropped after ack
  wb_hold_until_ack : assert property (
    @(posedge clk) disable iff (!arst_n)
    wb_req.stb |=> ($past(wb_rsp.ack) ? !wb_req.cyc : wb_req.stb && $stable(wb_req.adr))
  ) else $error("int_sequencer: wishbone read not held until ack");

endmodule

/* verilog/ret_sequencer.sv */
`timescale 1ns/100ps

module ret_sequencer (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    iretd,
  input  logic                    ret_far,
  input  logic                    ret_near,
  input  sys_cont_pkg::pop_t      pop,
  input  sys_cont_pkg::seg_t      cs_register,
  output logic                    halt,
  output sys_cont_pkg::redirect_t req
);

  import sys_cont_pkg::*;

  ret_state_t state;
  ret_state_t state_nx;
  logic       is_near;
  seg_t       temp_cs;
  seg_t       used_cs;

  ////////////////////////////////////////////////////////////
  // pop sequence
  ////////////////////////////////////////////////////////////

  // iretd pops three words, far ret two, near ret one
  always_comb begin
    state_nx = state;
    case (state)
      idle: begin
        if (iretd) begin
          state_nx = pop_eflags;
        end else if (ret_far) begin
          state_nx = pop_cs;
        end else if (ret_near) begin
          state_nx = pop_eip;
        end
      end
      pop_eflags: if (pop.valid) state_nx = pop_cs;
      pop_cs:     if (pop.valid) state_nx = pop_eip;
      pop_eip:    if (pop.valid) state_nx = idle;
      default:    state_nx = idle;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= idle;
      is_near <= 1'b0;
    end else begin
      state <= state_nx;
      if (state == idle) begin
        is_near <= ret_near;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == pop_cs && pop.valid) begin
      temp_cs <= pop.data.half.cs;
    end
  end

  assign halt    = (state != idle);
  assign used_cs = is_near ? cs_register : temp_cs;

  always_comb begin
    req             = '0;
    req.flush.fetch = halt;
    if (pop.valid) begin
      case (state)
        pop_eflags: begin
          req.load_eflags = 1'b1;
          req.eflags      = pop.data.word;
        end
        pop_cs: begin
          req.load_cs = 1'b1;
          req.cs      = pop.data.half.cs;
        end
        pop_eip: begin
          req.load_eip   = 1'b1;
          req.eip        = pop.data.word;
          req.fetch_load = 1'b1;
          req.fetch_addr = pop.data.word + {16'd0, used_cs};
        end
        default: ;
      endcase
    end
  end

  one_return_start : assert property (
    @(posedge clk) disable iff (!arst_n)
    $onehot0({iretd, ret_far, ret_near})
  ) else $error("ret_sequencer: more than one return started in %s", state.name());

endmodule

/* verilog/redirect_merge.sv */
`timescale 1ns/100ps

module redirect_merge (
  input  logic                    clk,
  input  logic                    arst_n,
  input  sys_cont_pkg::jump_t     jump,
  input  sys_cont_pkg::redirect_t int_req,
  input  sys_cont_pkg::redirect_t ret_req,
  output sys_cont_pkg::redirect_t redirect
);

  import sys_cont_pkg::*;

  logic      jump_load_q;
  logic      jump_cs_load_q;
  addr_t     jump_addr_q;
  seg_t      jump_cs_q;
  redirect_t jmp_req;
  redirect_t src [3];

  ////////////////////////////////////////////////////////////
  // jump stage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      jump_load_q    <= 1'b0;
      jump_cs_load_q <= 1'b0;
    end else begin
      jump_load_q    <= jump.load;
      jump_cs_load_q <= jump.load && jump.load_cs;
    end
  end

  always_ff @(posedge clk) begin
    jump_addr_q <= jump.address;
    jump_cs_q   <= jump.cs;
  end

  always_comb begin
    jmp_req = '0;
    if (jump_load_q) begin
      jmp_req.flush      = flush_front;
      jmp_req.fetch_load = 1'b1;
      jmp_req.fetch_addr = jump_addr_q;
      jmp_req.load_cs    = jump_cs_load_q;
      jmp_req.cs         = jump_cs_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // merge
  ////////////////////////////////////////////////////////////

  assign src[0] = int_req;
  assign src[1] = ret_req;
  assign src[2] = jmp_req;

  // flags are ORed, each field comes from whoever loads it
  always_comb begin
    redirect = '0;
    for (int i = 0; i < 3; i++) begin
      redirect.flush = flush_t'(redirect.flush | src[i].flush);
      if (src[i].fetch_load) begin
        redirect.fetch_load = 1'b1;
        redirect.fetch_addr = src[i].fetch_addr;
      end
      if (src[i].load_cs) begin
        redirect.load_cs = 1'b1;
        redirect.cs      = src[i].cs;
      end
      if (src[i].load_eip) begin
        redirect.load_eip = 1'b1;
        redirect.eip      = src[i].eip;
      end
      if (src[i].load_eflags) begin
        redirect.load_eflags = 1'b1;
        redirect.eflags      = src[i].eflags;
      end
    end
  end

  single_fetch_source : assert property (
    @(posedge clk) disable iff (!arst_n)
    $onehot0({int_req.fetch_load, ret_req.fetch_load, jmp_req.fetch_load})
  ) else $error("redirect_merge: two sources redirect fetch in one cycle");

endmodule

/* verilog/sys_cont_top.sv */
`timescale 1ns/100ps

module sys_cont_top #(
  parameter sys_cont_pkg::addr_t idt_base = 32'h4000
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  sys_cont_pkg::int_vec_t  int_vec,
  input  logic                    hold_int,
  input  logic                    decode_end_int,
  input  sys_cont_pkg::wb_rsp_t   wb_rsp,
  input  sys_cont_pkg::seg_t      cs_register,
  input  logic                    iretd,
  input  logic                    ret_far,
  input  logic                    ret_near,
  input  sys_cont_pkg::pop_t      pop,
  input  sys_cont_pkg::jump_t     jump,
  output logic                    pending_int,
  output logic                    decode_start_int,
  output sys_cont_pkg::wb_req_t   wb_req,
  output logic                    iretd_halt,
  output sys_cont_pkg::redirect_t redirect
);

  import sys_cont_pkg::*;

  vec_idx_t  serv_idx;
  vec_idx_t  clear_idx;
  logic      clear;
  redirect_t int_req;
  redirect_t ret_req;

  int_latch u_int_latch (
    .clk       (clk),
    .arst_n    (arst_n),
    .int_vec   (int_vec),
    .clear     (clear),
    .clear_idx (clear_idx),
    .pending   (pending_int),
    .serv_idx  (serv_idx)
  );

  int_sequencer #(
    .idt_base (idt_base)
  ) u_int_sequencer (
    .clk              (clk),
    .arst_n           (arst_n),
    .pending          (pending_int),
    .serv_idx         (serv_idx),
    .hold_int         (hold_int),
    .decode_end_int   (decode_end_int),
    .wb_rsp           (wb_rsp),
    .decode_start_int (decode_start_int),
    .wb_req           (wb_req),
    .clear            (clear),
    .clear_idx        (clear_idx),
    .req              (int_req)
  );

  ret_sequencer u_ret_sequencer (
    .clk         (clk),
    .arst_n      (arst_n),
    .iretd       (iretd),
    .ret_far     (ret_far),
    .ret_near    (ret_near),
    .pop         (pop),
    .cs_register (cs_register),
    .halt        (iretd_halt),
    .req         (ret_req)
  );

  redirect_merge u_redirect_merge (
    .clk      (clk),
    .arst_n   (arst_n),
    .jump     (jump),
    .int_req  (int_req),
    .ret_req  (ret_req),
    .redirect (redirect)
  );

endmodule

/* bench/tb_sys_cont_tasks.svh */
////////////////////////////////////////////////////////////
// reference model
////////////////////////////////////////////////////////////

typedef enum logic [1:0] {
  ev_jump,
  ev_int,
  ev_ret
} ev_kind_t;

// restart address for each kind of redirect
function automatic addr_t expect_fetch(ev_kind_t kind, word_t word, seg_t cs, vec_idx_t idx);
  addr_t addr;
  case (kind)
    ev_jump: addr = word;
    // idt memory returns its read address with bit 28 flipped
    ev_int:  addr = (idt_base + addr_t'(idx) * 4) ^ 32'h1000_0000;
    default: addr = word + addr_t'(cs);
  endcase
  return addr;
endfunction

task automatic check(string name, logic [31:0] got, logic [31:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("error %s: got %h, expected %h", name, got, exp);
  end
endtask

task automatic finish_test(string name, int mark);
  while (exp_q.size() != 0) @(posedge clk);
  repeat (2) @(posedge clk);
  tests_run++;
  if (errors == mark) begin
    $display("test %0d %s: ok", tests_run, name);
  end else begin
    tests_failed++;
    $display("test %0d %s: %0d errors", tests_run, name, errors - mark);
  end
endtask

////////////////////////////////////////////////////////////
// stimulus
////////////////////////////////////////////////////////////

task automatic issue_jump(addr_t addr, logic with_cs, seg_t cs);
  exp_t e;
  e                 = '0;
  e.addr            = expect_fetch(ev_jump, addr, cs, '0);
  e.flush           = '1;
  e.flush.writeback = 1'b0;
  e.load_cs         = with_cs;
  e.cs              = cs;
  @(posedge clk);
  exp_q.push_back(e);
  jump.load    <= 1'b1;
  jump.address <= addr;
  jump.load_cs <= with_cs;
  jump.cs      <= cs;
  @(negedge clk);
  check("redirect.fetch_load", redirect.fetch_load, 1'b0);
  @(posedge clk);
  jump <= '0;
  // load was sampled at this edge so the pulse fills the next cycle only
  @(negedge clk);
  check("redirect.fetch_load", redirect.fetch_load, 1'b1);
  @(negedge clk);
  check("redirect.fetch_load", redirect.fetch_load, 1'b0);
endtask

task automatic serve_three_ints();
  vec_idx_t order [3];
  exp_t     e;
  order = '{4'd3, 4'd9, 4'd12};
  @(posedge clk);
  foreach (order[i]) begin
    e                 = '0;
    e.addr            = expect_fetch(ev_int, '0, '0, order[i]);
    e.flush           = '1;
    e.flush.writeback = 1'b0;
    exp_q.push_back(e);
  end
  hold_int <= 1'b0;
  int_vec  <= (int_vec_t'(1) << 3) | (int_vec_t'(1) << 9) | (int_vec_t'(1) << 12);
  @(posedge clk);
  int_vec <= '0;
  while (exp_q.size() != 0) @(posedge clk);
  hold_int <= 1'b1;
  @(negedge clk);
  check("pending_int", pending_int, 1'b0);
  if (adr_log.size() != 3) begin
    errors++;
    $display("expected three IDT reads but saw %0d", adr_log.size());
  end
  foreach (order[i]) begin
    if (adr_log.size() != 0) begin
      check("wb_req.adr", adr_log.pop_front(), idt_base + 4 * order[i]);
    end
  end
endtask

task automatic hold_then_release();
  exp_t e;
  e                 = '0;
  e.addr            = expect_fetch(ev_int, '0, '0, 4'd5);
  e.flush           = '1;
  e.flush.writeback = 1'b0;
  @(posedge clk);
  int_vec <= int_vec_t'(1) << 5;
  @(posedge clk);
  int_vec <= '0;
  // line waits while the pipeline holds off service
  repeat (20) begin
    @(negedge clk);
    check("pending_int", pending_int, 1'b1);
    check("decode_start_int", decode_start_int, 1'b0);
    check("wb_req.cyc", wb_req.cyc, 1'b0);
    check("wb_req.stb", wb_req.stb, 1'b0);
  end
  @(posedge clk);
  exp_q.push_back(e);
  hold_int <= 1'b0;
  while (exp_q.size() != 0) @(posedge clk);
  hold_int <= 1'b1;
  adr_log.delete();
endtask

// stack side gives a random gap before each word
task automatic present_pop(word_t w);
  int gap;
  gap = $unsigned($random(seed)) % 4;
  @(posedge clk);
  pop.valid <= 1'b0;
  repeat (gap) @(posedge clk);
  pop.valid     <= 1'b1;
  pop.data.word <= w;
  @(negedge clk);
  check("iretd_halt", iretd_halt, 1'b1);
endtask

task automatic pop_return(ret_state_t first);
  word_t eflags_w;
  word_t cs_w;
  word_t eip_w;
  seg_t  cs_used;
  exp_t  e;
  eflags_w   = $random(seed);
  cs_w       = $random(seed);
  eip_w      = $random(seed);
  cs_used    = (first == pop_eip) ? cs_register : cs_w[15:0];
  e          = '0;
  e.addr     = expect_fetch(ev_ret, eip_w, cs_used, '0);
  e.flush    = '0;
  e.flush.fetch = 1'b1;
  e.load_eip = 1'b1;
  e.eip      = eip_w;
  @(posedge clk);
  exp_q.push_back(e);
  iretd    <= (first == pop_eflags);
  ret_far  <= (first == pop_cs);
  ret_near <= (first == pop_eip);
  @(posedge clk);
  iretd    <= 1'b0;
  ret_far  <= 1'b0;
  ret_near <= 1'b0;
  if (first == pop_eflags) begin
    present_pop(eflags_w);
    check("redirect.load_eflags", redirect.load_eflags, 1'b1);
    check("redirect.eflags", redirect.eflags, eflags_w);
  end
  if (first != pop_eip) begin
    present_pop(cs_w);
    check("redirect.load_cs", redirect.load_cs, 1'b1);
    check("redirect.cs", redirect.cs, cs_w[15:0]);
    check("redirect.load_eflags", redirect.load_eflags, 1'b0);
  end
  present_pop(eip_w);
  check("redirect.load_eflags", redirect.load_eflags, 1'b0);
  @(posedge clk);
  pop.valid <= 1'b0;
  @(negedge clk);
  check("iretd_halt", iretd_halt, 1'b0);
endtask

/* bench/tb_sys_cont.sv */
`timescale 1ns/100ps

module tb_sys_cont;

  import sys_cont_pkg::*;

  localparam addr_t idt_base       = 32'h4000;
  localparam int    num_tests      = 6;
  localparam int    timeout_cycles = num_tests * 200;

  // one expected fetch redirect
  typedef struct packed {
    addr_t  addr;
    flush_t flush;
    logic   load_cs;
    seg_t   cs;
    logic   load_eip;
    word_t  eip;
  } exp_t;

  logic      clk;
  logic      arst_n;
  int_vec_t  int_vec;
  logic      hold_int;
  logic      decode_end_int;
  wb_rsp_t   wb_rsp;
  seg_t      cs_register;
  logic      iretd;
  logic      ret_far;
  logic      ret_near;
  pop_t      pop;
  jump_t     jump;
  logic      pending_int;
  logic      decode_start_int;
  wb_req_t   wb_req;
  logic      iretd_halt;
  redirect_t redirect;

  integer seed;
  int     errors;
  int     checks;
  int     tests_run;
  int     tests_failed;
  int     cycles;
  int     wait_left;
  int     err_mark;
  exp_t   exp_q [$];
  addr_t  adr_log [$];
  exp_t   got_exp;

  `include "tb_sys_cont_tasks.svh"

  always #50 clk = ~clk;

  sys_cont_top #(
    .idt_base (idt_base)
  ) dut0 (
    .clk              (clk),
    .arst_n           (arst_n),
    .int_vec          (int_vec),
    .hold_int         (hold_int),
    .decode_end_int   (decode_end_int),
    .wb_rsp           (wb_rsp),
    .cs_register      (cs_register),
    .iretd            (iretd),
    .ret_far          (ret_far),
    .ret_near         (ret_near),
    .pop              (pop),
    .jump             (jump),
    .pending_int      (pending_int),
    .decode_start_int (decode_start_int),
    .wb_req           (wb_req),
    .iretd_halt       (iretd_halt),
    .redirect         (redirect)
  );

  ////////////////////////////////////////////////////////////
  // environment models
  ////////////////////////////////////////////////////////////

  // pipeline drain answers one cycle after the request
  always @(posedge clk) begin
    decode_end_int <= decode_start_int && !decode_end_int;
  end

  // idt memory with 0 to 3 wait states per read
  always @(posedge clk) begin
    if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) begin
      if (wait_left == 0) begin
        wb_rsp.ack <= 1'b1;
        wb_rsp.dat <= wb_req.adr ^ 32'h1000_0000;
        adr_log.push_back(wb_req.adr);
        wait_left  <= $unsigned($random(seed)) % 4;
      end else begin
        wait_left <= wait_left - 1;
      end
    end else begin
      wb_rsp.ack <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // compare and timeout
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (arst_n && redirect.fetch_load) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("unexpected fetch redirect to %h", redirect.fetch_addr);
      end else begin
        got_exp = exp_q.pop_front();
        check("redirect.fetch_addr", redirect.fetch_addr, got_exp.addr);
        check("redirect.flush", redirect.flush, got_exp.flush);
        check("redirect.load_cs", redirect.load_cs, got_exp.load_cs);
        if (got_exp.load_cs) begin
          check("redirect.cs", redirect.cs, got_exp.cs);
        end
        check("redirect.load_eip", redirect.load_eip, got_exp.load_eip);
        if (got_exp.load_eip) begin
          check("redirect.eip", redirect.eip, got_exp.eip);
        end
        check("redirect.load_eflags", redirect.load_eflags, 1'b0);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeout_cycles) begin
      $display("timeout, the run did not finish within %0d cycles", timeout_cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    clk            = 1'b0;
    arst_n         = 1'b0;
    int_vec        = '0;
    hold_int       = 1'b1;
    decode_end_int = 1'b0;
    wb_rsp         = '0;
    cs_register    = 16'h0123;
    iretd          = 1'b0;
    ret_far        = 1'b0;
    ret_near       = 1'b0;
    pop            = '0;
    jump           = '0;
    seed           = 82;
    errors         = 0;
    checks         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    cycles         = 0;
    wait_left      = 0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    repeat (2) @(posedge clk);

    err_mark = errors;
    issue_jump(32'h0001_2340, 1'b1, 16'h0008);
    issue_jump(32'h0000_8000, 1'b0, 16'h0010);
    finish_test("jump", err_mark);

    err_mark = errors;
    serve_three_ints();
    finish_test("interrupt priority", err_mark);

    err_mark = errors;
    hold_then_release();
    finish_test("hold_int", err_mark);

    err_mark = errors;
    pop_return(pop_eflags);
    finish_test("iretd", err_mark);

    err_mark = errors;
    pop_return(pop_cs);
    finish_test("far return", err_mark);

    err_mark = errors;
    pop_return(pop_eip);
    finish_test("near return", err_mark);

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+bench
verilog/sys_cont_pkg.sv
verilog/int_latch.sv
verilog/int_sequencer.sv
verilog/ret_sequencer.sv
verilog/redirect_merge.sv
verilog/sys_cont_top.sv
bench/tb_sys_cont.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := tb_sys_cont
FILELIST := compile.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(SIM), run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	@grep -q "TEST PASS" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
